// ==== mem_pkg.sv ====
package mem_pkg;

    // address and data geometry
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;

    // ram only decodes the low address bits
    localparam int RAM_DEPTH_LOG2 = 12;

    // ram read/write flag
    localparam logic RAM_RD = 1'b1;
    localparam logic RAM_WR = 1'b0;

    // one word, seen whole or as little-endian byte lanes
    typedef union packed {
        logic [WORD_W-1:0] word;
        logic [BYTES_PER_WORD-1:0][BYTE_W-1:0] bytes;
    } mem_word_u;

endpackage

// ==== ls_pkg.sv ====
package ls_pkg;

    // op code layout: [3] store, [2] unsigned, [1:0] log2 size
    localparam int LS_OP_W = 4;
    localparam int LS_STORE_BIT = 3;
    localparam int LS_UNS_BIT = 2;

    localparam logic [LS_OP_W-1:0] LS_LB = 4'b0000;
    localparam logic [LS_OP_W-1:0] LS_LH = 4'b0001;
    localparam logic [LS_OP_W-1:0] LS_LW = 4'b0010;
    localparam logic [LS_OP_W-1:0] LS_LBU = 4'b0100;
    localparam logic [LS_OP_W-1:0] LS_LHU = 4'b0101;
    localparam logic [LS_OP_W-1:0] LS_SB = 4'b1000;
    localparam logic [LS_OP_W-1:0] LS_SH = 4'b1001;
    localparam logic [LS_OP_W-1:0] LS_SW = 4'b1010;

    // byte counts, 1 to 4
    localparam int SIZE_W = 3;
    localparam logic [SIZE_W-1:0] SZ_BYTE = 3'd1;
    localparam logic [SIZE_W-1:0] SZ_HALF = 3'd2;
    localparam logic [SIZE_W-1:0] SZ_WORD = 3'd4;

endpackage

// ==== ram_byte.sv ====
module ram_byte (
    input  logic                         clk,
    input  logic                         ram_ena,
    input  logic                         ram_rd,
    input  logic [mem_pkg::ADDR_W-1:0]   ram_addr,
    input  logic [mem_pkg::BYTE_W-1:0]   ram_wdata,
    output logic [mem_pkg::BYTE_W-1:0]   ram_rdata
);
    import mem_pkg::*;

    localparam int RAM_SIZE = 2 ** RAM_DEPTH_LOG2;

    logic [BYTE_W-1:0] mem [RAM_SIZE];
    logic [RAM_DEPTH_LOG2-1:0] idx;

    assign idx = ram_addr[RAM_DEPTH_LOG2-1:0];

    // contents start cleared
    initial begin
        for (int i = 0; i < RAM_SIZE; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_ena && ram_rd == RAM_WR) begin
            mem[idx] <= ram_wdata;
        end
        // read data shows up one cycle later
        if (ram_ena && ram_rd == RAM_RD) begin
            ram_rdata <= mem[idx];
        end
    end

endmodule

// ==== mem_ctrl.sv ====
module mem_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         busy,
    output logic                         ram_ena,
    output logic                         ram_rd,
    output logic [mem_pkg::ADDR_W-1:0]   ram_addr,
    output logic [mem_pkg::BYTE_W-1:0]   ram_wdata,
    input  logic [mem_pkg::BYTE_W-1:0]   ram_rdata,
    input  logic                         fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0]   fetch_addr,
    output logic                         fetch_ok,
    output mem_pkg::mem_word_u           fetch_data,
    input  logic                         ls_req,
    input  logic                         ls_write,
    input  logic [ls_pkg::SIZE_W-1:0]    ls_size,
    input  logic [mem_pkg::ADDR_W-1:0]   ls_addr,
    input  logic [mem_pkg::WORD_W-1:0]   ls_wdata,
    output logic                         ls_ok,
    output mem_pkg::mem_word_u           ls_rdata
);
    import mem_pkg::*;
    import ls_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FETCH_RD = 2'd1;
    localparam logic [1:0] ST_LS_RD = 2'd2;
    localparam logic [1:0] ST_LS_WR = 2'd3;

    logic [1:0] state;

    // one waiting request per port
    logic              fetch_pend;
    logic [ADDR_W-1:0] fetch_addr_q;
    logic              ls_pend;
    logic              ls_write_q;
    logic [SIZE_W-1:0] ls_size_q;
    logic [ADDR_W-1:0] ls_addr_q;
    logic [WORD_W-1:0] ls_wdata_q;

    logic              ls_go;
    logic              fetch_go;
    logic              sel_write;
    logic [SIZE_W-1:0] sel_size;
    logic [ADDR_W-1:0] sel_ls_addr;
    logic [ADDR_W-1:0] sel_fetch_addr;
    mem_word_u         sel_wdata;

    // byte-serial access
    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        cnt;
    logic [1:0]        stop;
    mem_word_u         data_q;
    mem_word_u         rd_word;

    // a pending copy wins over the live inputs
    always_comb begin
        ls_go = ls_req || ls_pend;
        fetch_go = !ls_go && (fetch_req || fetch_pend);
        sel_write = ls_pend ? ls_write_q : ls_write;
        sel_size = ls_pend ? ls_size_q : ls_size;
        sel_ls_addr = ls_pend ? ls_addr_q : ls_addr;
        sel_wdata.word = ls_pend ? ls_wdata_q : ls_wdata;
        sel_fetch_addr = fetch_pend ? fetch_addr_q : fetch_addr;
        rd_word = data_q;
        rd_word.bytes[cnt] = ram_rdata;
    end

    // first byte goes out on the serving cycle
    always_comb begin
        if (state == ST_IDLE) begin
            ram_ena = ls_go || fetch_go;
            ram_rd = (ls_go && sel_write) ? RAM_WR : RAM_RD;
            ram_addr = ls_go ? sel_ls_addr : sel_fetch_addr;
            ram_wdata = sel_wdata.bytes[0];
        end else begin
            // reads stop issuing once the last lane is in flight
            ram_ena = (state == ST_LS_WR) || (cnt != stop);
            ram_rd = (state == ST_LS_WR) ? RAM_WR : RAM_RD;
            ram_addr = addr_q;
            ram_wdata = data_q.bytes[cnt];
        end
    end

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            fetch_pend <= 1'b0;
            ls_pend <= 1'b0;
            fetch_ok <= 1'b0;
            ls_ok <= 1'b0;
        end else begin
            fetch_ok <= 1'b0;
            ls_ok <= 1'b0;
            if (fetch_req) begin
                fetch_pend <= 1'b1;
                fetch_addr_q <= fetch_addr;
            end
            if (ls_req) begin
                ls_pend <= 1'b1;
                ls_write_q <= ls_write;
                ls_size_q <= ls_size;
                ls_addr_q <= ls_addr;
                ls_wdata_q <= ls_wdata;
            end
            case (state)
                ST_IDLE: begin
                    if (ls_go) begin
                        ls_pend <= 1'b0;
                        addr_q <= sel_ls_addr + 1'b1;
                        stop <= 2'(sel_size - 1'b1);
                        if (sel_write) begin
                            data_q <= sel_wdata;
                            cnt <= 2'd1;
                            // single byte already written this cycle
                            if (sel_size == SZ_BYTE) begin
                                ls_ok <= 1'b1;
                                ls_rdata <= '0;
                            end else begin
                                state <= ST_LS_WR;
                            end
                        end else begin
                            data_q <= '0;
                            cnt <= 2'd0;
                            state <= ST_LS_RD;
                        end
                    end else if (fetch_go) begin
                        fetch_pend <= 1'b0;
                        addr_q <= sel_fetch_addr + 1'b1;
                        stop <= 2'(SZ_WORD - 1'b1);
                        data_q <= '0;
                        cnt <= 2'd0;
                        state <= ST_FETCH_RD;
                    end
                end
                ST_FETCH_RD, ST_LS_RD: begin
                    addr_q <= addr_q + 1'b1;
                    cnt <= cnt + 1'b1;
                    data_q <= rd_word;
                    if (cnt == stop) begin
                        state <= ST_IDLE;
                        if (state == ST_FETCH_RD) begin
                            fetch_ok <= 1'b1;
                            fetch_data <= rd_word;
                        end else begin
                            ls_ok <= 1'b1;
                            ls_rdata <= rd_word;
                        end
                    end
                end
                default: begin
                    addr_q <= addr_q + 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt == stop) begin
                        ls_ok <= 1'b1;
                        ls_rdata <= '0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== ls_unit.sv ====
module ls_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ls_req,
    input  logic [ls_pkg::LS_OP_W-1:0]   ls_op,
    input  logic [mem_pkg::ADDR_W-1:0]   ls_addr,
    input  logic [mem_pkg::WORD_W-1:0]   ls_wdata,
    output logic                         ls_ok,
    output logic [mem_pkg::WORD_W-1:0]   ls_rdata,
    output logic                         mc_ls_req,
    output logic                         mc_ls_write,
    output logic [ls_pkg::SIZE_W-1:0]    mc_ls_size,
    output logic [mem_pkg::ADDR_W-1:0]   mc_ls_addr,
    output logic [mem_pkg::WORD_W-1:0]   mc_ls_wdata,
    input  logic                         mc_ls_ok,
    input  mem_pkg::mem_word_u           mc_ls_rdata
);
    import mem_pkg::*;
    import ls_pkg::*;

    logic              pend_uns;
    logic [SIZE_W-1:0] pend_size;
    logic [WORD_W-1:0] raw;
    logic [WORD_W-1:0] ext;

    assign mc_ls_req = ls_req;
    assign mc_ls_write = ls_op[LS_STORE_BIT];
    assign mc_ls_addr = ls_addr;
    assign mc_ls_wdata = ls_wdata;

    always_comb begin
        case (ls_op[1:0])
            2'b00: mc_ls_size = SZ_BYTE;
            2'b01: mc_ls_size = SZ_HALF;
            default: mc_ls_size = SZ_WORD;
        endcase
    end

    // controller zero-fills above the size, so only the sign needs work
    always_comb begin
        raw = mc_ls_rdata.word;
        case (pend_size)
            SZ_BYTE: ext = {{(WORD_W-BYTE_W){!pend_uns && raw[BYTE_W-1]}}, raw[BYTE_W-1:0]};
            SZ_HALF: ext = {{(WORD_W-2*BYTE_W){!pend_uns && raw[2*BYTE_W-1]}},
                            raw[2*BYTE_W-1:0]};
            default: ext = raw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ls_req) begin
            pend_uns <= ls_op[LS_UNS_BIT];
            pend_size <= mc_ls_size;
        end
        if (mc_ls_ok) begin
            ls_rdata <= ext;
        end
        if (rst) begin
            ls_ok <= 1'b0;
        end else begin
            ls_ok <= mc_ls_ok;
        end
    end

endmodule

// ==== fetch_buffer.sv ====
module fetch_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0]   fetch_addr,
    output logic                         fetch_ok,
    output logic [mem_pkg::WORD_W-1:0]   fetch_inst,
    input  logic                         store_seen,
    output logic                         mc_fetch_req,
    output logic [mem_pkg::ADDR_W-1:0]   mc_fetch_addr,
    input  logic                         mc_fetch_ok,
    input  mem_pkg::mem_word_u           mc_fetch_data
);
    import mem_pkg::*;

    logic              valid;
    logic [ADDR_W-1:0] tag;
    logic [WORD_W-1:0] word_q;
    logic              hit;

    // a write in flight this cycle makes the held word suspect
    assign hit = valid && !store_seen && (fetch_addr == tag);

    assign mc_fetch_req = fetch_req && !hit;
    assign mc_fetch_addr = fetch_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            fetch_ok <= 1'b0;
        end else begin
            fetch_ok <= 1'b0;
            if (fetch_req && hit) begin
                fetch_ok <= 1'b1;
                fetch_inst <= word_q;
            end
            // miss drops the old entry until the reply fills it
            if (mc_fetch_req) begin
                valid <= 1'b0;
                tag <= fetch_addr;
            end
            if (mc_fetch_ok) begin
                fetch_ok <= 1'b1;
                fetch_inst <= mc_fetch_data.word;
                word_q <= mc_fetch_data.word;
                valid <= 1'b1;
            end
            if (store_seen) begin
                valid <= 1'b0;
            end
        end
    end

endmodule

// ==== mem_subsys.sv ====
module mem_subsys (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_req,
    input  logic [mem_pkg::ADDR_W-1:0]   fetch_addr,
    output logic                         fetch_ok,
    output logic [mem_pkg::WORD_W-1:0]   fetch_inst,
    input  logic                         ls_req,
    input  logic [ls_pkg::LS_OP_W-1:0]   ls_op,
    input  logic [mem_pkg::ADDR_W-1:0]   ls_addr,
    input  logic [mem_pkg::WORD_W-1:0]   ls_wdata,
    output logic                         ls_ok,
    output logic [mem_pkg::WORD_W-1:0]   ls_rdata,
    output logic                         busy
);
    import mem_pkg::*;
    import ls_pkg::*;

    logic              mc_fetch_req;
    logic [ADDR_W-1:0] mc_fetch_addr;
    logic              mc_fetch_ok;
    mem_word_u         mc_fetch_data;

    logic              mc_ls_req;
    logic              mc_ls_write;
    logic [SIZE_W-1:0] mc_ls_size;
    logic [ADDR_W-1:0] mc_ls_addr;
    logic [WORD_W-1:0] mc_ls_wdata;
    logic              mc_ls_ok;
    mem_word_u         mc_ls_rdata;

    logic              ram_ena;
    logic              ram_rd;
    logic [ADDR_W-1:0] ram_addr;
    logic [BYTE_W-1:0] ram_wdata;
    logic [BYTE_W-1:0] ram_rdata;
    logic              store_seen;

    // only the load/store port writes the ram
    assign store_seen = ram_ena && (ram_rd == RAM_WR);

    fetch_buffer u_fetch_buffer (
        .clk(clk), .rst(rst),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ok(fetch_ok), .fetch_inst(fetch_inst),
        .store_seen(store_seen),
        .mc_fetch_req(mc_fetch_req), .mc_fetch_addr(mc_fetch_addr),
        .mc_fetch_ok(mc_fetch_ok), .mc_fetch_data(mc_fetch_data)
    );

    ls_unit u_ls_unit (
        .clk(clk), .rst(rst),
        .ls_req(ls_req), .ls_op(ls_op), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
        .ls_ok(ls_ok), .ls_rdata(ls_rdata),
        .mc_ls_req(mc_ls_req), .mc_ls_write(mc_ls_write), .mc_ls_size(mc_ls_size),
        .mc_ls_addr(mc_ls_addr), .mc_ls_wdata(mc_ls_wdata),
        .mc_ls_ok(mc_ls_ok), .mc_ls_rdata(mc_ls_rdata)
    );

    mem_ctrl u_mem_ctrl (
        .clk(clk), .rst(rst), .busy(busy),
        .ram_ena(ram_ena), .ram_rd(ram_rd), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
        .fetch_req(mc_fetch_req), .fetch_addr(mc_fetch_addr),
        .fetch_ok(mc_fetch_ok), .fetch_data(mc_fetch_data),
        .ls_req(mc_ls_req), .ls_write(mc_ls_write), .ls_size(mc_ls_size),
        .ls_addr(mc_ls_addr), .ls_wdata(mc_ls_wdata),
        .ls_ok(mc_ls_ok), .ls_rdata(mc_ls_rdata)
    );

    ram_byte u_ram_byte (
        .clk(clk), .ram_ena(ram_ena), .ram_rd(ram_rd), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

endmodule

// ==== tb_mem_subsys.sv ====
module tb_mem_subsys;
    import mem_pkg::*;
    import ls_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int DIRECTED_OPS = 40;
    localparam int RANDOM_OPS = 300;
    localparam int CYCLES_PER_OP = 20;

    logic               clk;
    logic               rst;
    logic               fetch_req;
    logic [ADDR_W-1:0]  fetch_addr;
    logic               fetch_ok;
    logic [WORD_W-1:0]  fetch_inst;
    logic               ls_req;
    logic [LS_OP_W-1:0] ls_op;
    logic [ADDR_W-1:0]  ls_addr;
    logic [WORD_W-1:0]  ls_wdata;
    logic               ls_ok;
    logic [WORD_W-1:0]  ls_rdata;
    logic               busy;

    // reference memory, same size as the ram
    logic [BYTE_W-1:0] ref_mem [2**RAM_DEPTH_LOG2];

    // expected results, queued when a request is issued
    logic [WORD_W-1:0] exp_ls_q [$];
    bit                ls_store_q [$];
    logic [WORD_W-1:0] exp_fetch_q [$];
    logic [WORD_W-1:0] exp_ls;
    logic [WORD_W-1:0] exp_fetch;
    bit                exp_store;

    int          ls_issued;
    int          ls_done;
    int          fetch_issued;
    int          fetch_done;
    int          checks;
    int          errors;
    logic [31:0] rng_state;

    mem_subsys uut (
        .clk(clk), .rst(rst),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ok(fetch_ok), .fetch_inst(fetch_inst),
        .ls_req(ls_req), .ls_op(ls_op), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
        .ls_ok(ls_ok), .ls_rdata(ls_rdata),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [BYTE_W-1:0] ref_byte(input logic [ADDR_W-1:0] addr);
        return ref_mem[addr[RAM_DEPTH_LOG2-1:0]];
    endfunction

    // little-endian word from the model
    function automatic logic [WORD_W-1:0] fetch_expect(input logic [ADDR_W-1:0] addr);
        return {ref_byte(addr + 32'd3), ref_byte(addr + 32'd2),
                ref_byte(addr + 32'd1), ref_byte(addr)};
    endfunction

    function automatic logic [WORD_W-1:0] load_expect(input logic [LS_OP_W-1:0] op,
                                                      input logic [ADDR_W-1:0] addr);
        logic [BYTE_W-1:0] b0;
        logic [BYTE_W-1:0] b1;
        b0 = ref_byte(addr);
        b1 = ref_byte(addr + 32'd1);
        case (op)
            LS_LB: return {{24{b0[7]}}, b0};
            LS_LBU: return {24'd0, b0};
            LS_LH: return {{16{b1[7]}}, b1, b0};
            LS_LHU: return {16'd0, b1, b0};
            default: return fetch_expect(addr);
        endcase
    endfunction

    task automatic model_store(input logic [LS_OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                               input logic [WORD_W-1:0] wdata);
        int n;
        logic [ADDR_W-1:0] a;
        n = 1 << op[1:0];
        for (int i = 0; i < n; i++) begin
            a = addr + 32'(i);
            ref_mem[a[RAM_DEPTH_LOG2-1:0]] = wdata[8*i +: 8];
        end
    endtask

    task automatic next_rand(output logic [31:0] r);
        // upper halves only, the low lcg bits repeat too soon
        rng_state = lcg_step(rng_state);
        r[31:16] = rng_state[31:16];
        rng_state = lcg_step(rng_state);
        r[15:0] = rng_state[31:16];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // one-cycle strobes on either port or both
    task automatic issue(input bit do_f, input logic [ADDR_W-1:0] faddr, input bit do_l,
                         input logic [LS_OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                         input logic [WORD_W-1:0] wdata);
        @(posedge clk);
        #1;
        if (do_l) begin
            if (op[LS_STORE_BIT]) begin
                model_store(op, addr, wdata);
                exp_ls_q.push_back('0);
                ls_store_q.push_back(1'b1);
            end else begin
                exp_ls_q.push_back(load_expect(op, addr));
                ls_store_q.push_back(1'b0);
            end
            ls_issued++;
            ls_req = 1'b1;
            ls_op = op;
            ls_addr = addr;
            ls_wdata = wdata;
        end
        if (do_f) begin
            exp_fetch_q.push_back(fetch_expect(faddr));
            fetch_issued++;
            fetch_req = 1'b1;
            fetch_addr = faddr;
        end
        @(posedge clk);
        #1;
        ls_req = 1'b0;
        fetch_req = 1'b0;
        // only a single-byte store finishes within the serving cycle
        if (do_l && op != LS_SB) begin
            check_value("busy", 32'(busy), 32'd1);
        end
    endtask

    task automatic wait_done();
        while (ls_done < ls_issued || fetch_done < fetch_issued) begin
            @(posedge clk);
        end
    endtask

    task automatic run_step(input bit do_f, input logic [ADDR_W-1:0] faddr, input bit do_l,
                            input logic [LS_OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                            input logic [WORD_W-1:0] wdata);
        issue(do_f, faddr, do_l, op, addr, wdata);
        wait_done();
    endtask

    task automatic run_ls(input logic [LS_OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata);
        run_step(1'b0, '0, 1'b1, op, addr, wdata);
    endtask

    task automatic run_fetch(input logic [ADDR_W-1:0] addr);
        run_step(1'b1, addr, 1'b0, LS_LW, '0, '0);
    endtask

    task automatic random_step();
        logic [31:0] r;
        logic [31:0] d;
        logic [LS_OP_W-1:0] op;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] fa;
        next_rand(r);
        next_rand(d);
        if (r[1:0] == 2'd0) begin
            case (r[3:2])
                2'd0: op = LS_SB;
                2'd1: op = LS_SH;
                default: op = LS_SW;
            endcase
        end else begin
            case (r[4:2])
                3'd0: op = LS_LB;
                3'd1: op = LS_LBU;
                3'd2: op = LS_LH;
                3'd3: op = LS_LHU;
                default: op = LS_LW;
            endcase
        end
        // 64 bytes, naturally aligned
        a = 32'h40 + 32'(r[13:8]);
        a = a & ~((32'd1 << op[1:0]) - 32'd1);
        fa = 32'h40 + 32'({r[19:16], 2'b00});
        case (r[1:0])
            2'd2: run_step(1'b1, fa, 1'b0, op, a, d);
            2'd3: run_step(1'b1, fa, 1'b1, op, a, d);
            default: begin
                if (r[20]) begin
                    // load/store lands while a fetch miss is still being served
                    issue(1'b1, fa, 1'b0, op, a, d);
                    run_step(1'b0, fa, 1'b1, op, a, d);
                end else begin
                    run_step(1'b0, fa, 1'b1, op, a, d);
                end
            end
        endcase
    endtask

    // compares every completion against the queued expectation
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && ls_ok) begin
                if (exp_ls_q.size() == 0) begin
                    errors++;
                    $display("ls_ok pulsed with no load or store outstanding at %0t", $time);
                end else begin
                    exp_ls = exp_ls_q.pop_front();
                    exp_store = ls_store_q.pop_front();
                    if (!exp_store) begin
                        check_value("ls_rdata", ls_rdata, exp_ls);
                    end
                    ls_done++;
                end
            end
            if (!rst && fetch_ok) begin
                if (exp_fetch_q.size() == 0) begin
                    errors++;
                    $display("fetch_ok pulsed with no fetch outstanding at %0t", $time);
                end else begin
                    exp_fetch = exp_fetch_q.pop_front();
                    check_value("fetch_inst", fetch_inst, exp_fetch);
                    fetch_done++;
                end
            end
        end
    end

    initial begin
        #((RESET_CYCLES + (DIRECTED_OPS + RANDOM_OPS) * CYCLES_PER_OP) * CLK_PERIOD);
        $display("watchdog expired with requests still outstanding");
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        ls_req = 1'b0;
        ls_op = '0;
        ls_addr = '0;
        ls_wdata = '0;
        rng_state = 32'h88ad;
        for (int i = 0; i < 2**RAM_DEPTH_LOG2; i++) begin
            ref_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // stores merged into the prior word
        run_ls(LS_SW, 32'h20, 32'h11223344);
        run_ls(LS_LW, 32'h20, 32'h0);
        run_ls(LS_SB, 32'h21, 32'h000000a5);
        run_ls(LS_LW, 32'h20, 32'h0);
        run_ls(LS_SB, 32'h22, 32'hffffff3c);
        run_ls(LS_LW, 32'h20, 32'h0);
        run_ls(LS_SH, 32'h22, 32'h1234beef);
        run_ls(LS_LW, 32'h20, 32'h0);
        run_ls(LS_SW, 32'h24, 32'hcafef00d);
        run_ls(LS_LW, 32'h24, 32'h0);

        // sign and zero extension, top bit set and clear
        run_ls(LS_SW, 32'h30, 32'h7f808001);
        for (int i = 0; i < 4; i++) begin
            run_ls(LS_LB, 32'h30 + 32'(i), 32'h0);
            run_ls(LS_LBU, 32'h30 + 32'(i), 32'h0);
        end
        for (int i = 0; i < 4; i += 2) begin
            run_ls(LS_LH, 32'h30 + 32'(i), 32'h0);
            run_ls(LS_LHU, 32'h30 + 32'(i), 32'h0);
        end

        run_fetch(32'h20);
        run_fetch(32'h24);
        run_fetch(32'h30);

        // both ports strobed together, buffer misses each time
        run_step(1'b1, 32'h24, 1'b1, LS_LW, 32'h30, 32'h0);
        run_step(1'b1, 32'h30, 1'b1, LS_LH, 32'h22, 32'h0);

        // repeat hits, then stores must invalidate the buffer
        run_fetch(32'h28);
        run_fetch(32'h28);
        run_ls(LS_SW, 32'h28, 32'h0badc0de);
        run_fetch(32'h28);
        run_fetch(32'h28);
        run_ls(LS_SB, 32'h2b, 32'h00000077);
        run_fetch(32'h28);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            random_step();
        end
        wait_done();
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
mem_pkg.sv
ls_pkg.sv
ram_byte.sv
mem_ctrl.sv
ls_unit.sv
fetch_buffer.sv
mem_subsys.sv
tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides the result, not the simulator exit code
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "no completion line in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
